//--- build.f
common/isa_pkg.sv
common/fetch_pkg.sv
fetch/instr_fetch.sv
fetch/instr_rom.sv
fetch/fetch_buffer.sv
design/instr_predecode.sv
design/fetch_top.sv
test/tb_clock.sv
test/tb_fetch_top.sv

//--- common/fetch_pkg.sv
// types shared along the fetch path
// the ROM is word addressed, so a request carries pc[31:2]
// buffer depth must stay a power of two for the pointer wrap

`default_nettype none

package fetch_pkg;

  localparam int FETCH_BUF_DEPTH = 4;                    // buffer entries
  localparam int FETCH_BUF_AW    = $clog2(FETCH_BUF_DEPTH);
  localparam int FETCH_CNT_W     = FETCH_BUF_AW + 1;     // count reaches DEPTH
  localparam int ROM_WORDS       = 64;                   // instruction words
  localparam int ROM_AW          = $clog2(ROM_WORDS);

  // one instruction with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [29:0] addr;   // word address
  } rom_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } rom_rsp_t;

  // taken jump seen by the predecoder
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  typedef enum logic {
    FS_RUN,   // fetching
    FS_EXC    // dead after a misaligned jump, left only by reset
  } fetch_state_e;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
// RV32I instruction classes as seen by the predecoder
// only bits 6:0 are looked at, so funct fields are not checked for legality
// compressed instructions are not supported

`default_nettype none

package isa_pkg;

  //////////////////////////////
  // instruction classes
  //////////////////////////////

  // one entry per major opcode of the base ISA
  typedef enum logic [3:0] {
    OP_LUI,      // 0110111
    OP_AUIPC,    // 0010111
    OP_JAL,      // 1101111
    OP_JALR,     // 1100111
    OP_BRANCH,   // 1100011
    OP_LOAD,     // 0000011
    OP_STORE,    // 0100011
    OP_IMM,      // 0010011
    OP_REG,      // 0110011
    OP_FENCE,    // 0001111
    OP_SYSTEM,   // 1110011
    OP_ILLEGAL   // anything else
  } opcode_e;

  // addi x0, x0, 0
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  //////////////////////////////
  // decoded instruction
  //////////////////////////////

  typedef struct packed {
    logic [31:0] pc;       // address of the instruction
    logic [31:0] instr;    // raw instruction word
    opcode_e     op;       // class from bits 6:0
    logic [4:0]  rd;       // bits 11:7
    logic [20:0] jal_imm;  // J-type offset, bit 0 always zero
  } decoded_t;

endpackage

`default_nettype wire

//--- design/fetch_top.sv
// instruction front end: fetch, ROM, buffer and predecode
// BOOT_ADDR must be word aligned and inside the ROM to fetch real code
// exception_o stays high until reset

`default_nettype none

module fetch_top #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic              clk_i,
  input  logic              rstn_i,
  input  logic              dec_ready_i,
  output isa_pkg::decoded_t dec_o,
  output logic              dec_valid_o,
  output logic              exception_o,
  output logic [31:0]       fault_addr_o
);
  import fetch_pkg::*;

  rom_req_t   rom_req;
  rom_rsp_t   rom_rsp;
  fetch_pkt_t push_pkt;
  fetch_pkt_t buf_pkt;
  redirect_t  redirect;   // from predecode to fetch and buffer
  logic       push;
  logic       almost_full;
  logic       buf_valid;
  logic       pre_ready;

  instr_fetch u_instr_fetch (
    .clk_i             (clk_i),
    .rstn_i            (rstn_i),
    .boot_addr_i       (BOOT_ADDR),
    .rom_rsp_i         (rom_rsp),
    .buf_almost_full_i (almost_full),
    .redirect_i        (redirect),
    .rom_req_o         (rom_req),
    .push_o            (push),
    .push_pkt_o        (push_pkt),
    .exception_o       (exception_o),
    .fault_addr_o      (fault_addr_o)
  );

  instr_rom u_instr_rom (
    .clk_i  (clk_i),
    .rstn_i (rstn_i),
    .req_i  (rom_req),
    .rsp_o  (rom_rsp)
  );

  // a taken JAL flushes whatever was fetched behind it
  fetch_buffer u_fetch_buffer (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .push_i        (push),
    .push_pkt_i    (push_pkt),
    .flush_i       (redirect.valid),
    .pop_ready_i   (pre_ready),
    .almost_full_o (almost_full),
    .pop_valid_o   (buf_valid),
    .pop_pkt_o     (buf_pkt)
  );

  instr_predecode u_instr_predecode (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .in_valid_i  (buf_valid),
    .in_pkt_i    (buf_pkt),
    .dec_ready_i (dec_ready_i),
    .in_ready_o  (pre_ready),
    .redirect_o  (redirect),
    .dec_o       (dec_o),
    .dec_valid_o (dec_valid_o)
  );

endmodule

`default_nettype wire

//--- design/instr_predecode.sv
// registered predecode stage with a single output slot
// only JAL redirects, JALR and branches are just classified
// redirect_o is combinational from the accepted input

`default_nettype none

module instr_predecode (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  in_valid_i,
  input  fetch_pkg::fetch_pkt_t in_pkt_i,
  input  logic                  dec_ready_i,
  output logic                  in_ready_o,
  output fetch_pkg::redirect_t  redirect_o,
  output isa_pkg::decoded_t     dec_o,
  output logic                  dec_valid_o
);
  import isa_pkg::*;

  decoded_t dec_d;
  logic     accept;

  // slot free now or emptied this cycle
  assign in_ready_o = !dec_valid_o || dec_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  //////////////////////////////
  // field extraction
  //////////////////////////////

  always_comb begin
    dec_d.pc      = in_pkt_i.pc;
    dec_d.instr   = in_pkt_i.instr;
    dec_d.rd      = in_pkt_i.instr[11:7];
    // J-type immediate, imm[20|10:1|11|19:12] in bits 31:12
    dec_d.jal_imm = {in_pkt_i.instr[31], in_pkt_i.instr[19:12],
                     in_pkt_i.instr[20], in_pkt_i.instr[30:21], 1'b0};
    case (in_pkt_i.instr[6:0])
      7'b0110111: dec_d.op = OP_LUI;
      7'b0010111: dec_d.op = OP_AUIPC;
      7'b1101111: dec_d.op = OP_JAL;
      7'b1100111: dec_d.op = OP_JALR;
      7'b1100011: dec_d.op = OP_BRANCH;
      7'b0000011: dec_d.op = OP_LOAD;
      7'b0100011: dec_d.op = OP_STORE;
      7'b0010011: dec_d.op = OP_IMM;
      7'b0110011: dec_d.op = OP_REG;
      7'b0001111: dec_d.op = OP_FENCE;
      7'b1110011: dec_d.op = OP_SYSTEM;
      default:    dec_d.op = OP_ILLEGAL;
    endcase
  end

  // jump target is pc plus sign-extended offset
  assign redirect_o.valid  = accept && (dec_d.op == OP_JAL);
  assign redirect_o.target = in_pkt_i.pc + {{11{dec_d.jal_imm[20]}}, dec_d.jal_imm};

  //////////////////////////////
  // output slot
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_valid_o   <= 1'b0;
      dec_o.pc      <= 32'h0;
      dec_o.instr   <= NOP_INSTR;
      dec_o.op      <= OP_IMM;       // class of the NOP
      dec_o.rd      <= 5'd0;
      dec_o.jal_imm <= 21'd0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
      dec_o       <= dec_d;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;           // taken, nothing new behind it
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // downstream stall holds the slot untouched
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (dec_valid_o && !dec_ready_i) |=> (dec_valid_o && $stable(dec_o))
  ) else $error("dec_o changed under back-pressure");

endmodule

`default_nettype wire

//--- fetch/fetch_buffer.sv
// small FIFO between fetch and predecode
// flush wins over push and pop in the same cycle
// almost_full_o rises with fewer than two free entries

`default_nettype none

module fetch_buffer (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  push_i,
  input  fetch_pkg::fetch_pkt_t push_pkt_i,
  input  logic                  flush_i,
  input  logic                  pop_ready_i,
  output logic                  almost_full_o,
  output logic                  pop_valid_o,
  output fetch_pkg::fetch_pkt_t pop_pkt_o
);
  import fetch_pkg::*;

  fetch_pkt_t              mem_q [FETCH_BUF_DEPTH];
  logic [FETCH_BUF_AW-1:0] wr_ptr_q;
  logic [FETCH_BUF_AW-1:0] rd_ptr_q;
  logic [FETCH_CNT_W-1:0]  count_q;
  logic                    push_en;
  logic                    pop_en;

  assign push_en = push_i && !flush_i;        // wrong-path data is dropped
  assign pop_en  = pop_valid_o && pop_ready_i;

  assign pop_valid_o   = (count_q != '0);
  assign pop_pkt_o     = mem_q[rd_ptr_q];     // head, valid a cycle after push
  assign almost_full_o = (count_q >= FETCH_CNT_W'(FETCH_BUF_DEPTH - 1));

  //////////////////////////////
  // pointers and count
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is 2^n
      if (pop_en)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_en, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;           // none, or both at once
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_pkt_i;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // fetch must throttle on almost_full early enough
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    push_en |-> (count_q != FETCH_CNT_W'(FETCH_BUF_DEPTH))
  ) else $error("push into full fetch buffer");

  a_count_bound : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    count_q <= FETCH_CNT_W'(FETCH_BUF_DEPTH)
  ) else $error("fetch buffer count %0d out of range", count_q);

endmodule

`default_nettype wire

//--- fetch/instr_fetch.sv
// program counter and ROM request side of the front end
// ROM answers exactly one cycle after a request, with no back-pressure
// a misaligned redirect stops fetch until reset

`default_nettype none

module instr_fetch (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic [31:0]           boot_addr_i,
  input  fetch_pkg::rom_rsp_t   rom_rsp_i,
  input  logic                  buf_almost_full_i,
  input  fetch_pkg::redirect_t  redirect_i,
  output fetch_pkg::rom_req_t   rom_req_o,
  output logic                  push_o,
  output fetch_pkg::fetch_pkt_t push_pkt_o,
  output logic                  exception_o,
  output logic [31:0]           fault_addr_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  logic [31:0]  pc_q;           // address of the next request
  logic [31:0]  inflight_pc_q;  // address of the read now in the ROM
  logic         pending_q;      // read in flight is still wanted
  logic         misaligned;
  logic         jump_ok;

  //////////////////////////////
  // redirect check
  //////////////////////////////

  // jump targets must be word aligned, there is no C extension
  assign misaligned = redirect_i.valid && (redirect_i.target[1:0] != 2'b00);
  assign jump_ok    = redirect_i.valid && !misaligned;

  //////////////////////////////
  // request and push
  //////////////////////////////

  // almost full leaves room for the one read in flight
  assign rom_req_o.valid = (state_q == FS_RUN) && !buf_almost_full_i;
  assign rom_req_o.addr  = pc_q[31:2];

  // a redirect kills the response arriving in the same cycle as well
  assign push_o           = rom_rsp_i.valid && pending_q && !redirect_i.valid;
  assign push_pkt_o.pc    = inflight_pc_q;
  assign push_pkt_o.instr = rom_rsp_i.data;

  //////////////////////////////
  // control state
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      state_q      <= FS_RUN;
      pc_q         <= boot_addr_i;
      pending_q    <= 1'b0;
      exception_o  <= 1'b0;
      fault_addr_o <= 32'h0;
    end else begin
      // a request issued now is dropped if a redirect arrives with it
      pending_q <= rom_req_o.valid && !redirect_i.valid;
      if (jump_ok) begin
        pc_q <= redirect_i.target;       // first request at target next cycle
      end else if (rom_req_o.valid) begin
        pc_q <= pc_q + 32'd4;            // sequential step
      end
      if (misaligned) begin
        state_q      <= FS_EXC;
        exception_o  <= 1'b1;
        fault_addr_o <= redirect_i.target; // report the bad target itself
      end
    end
  end

  // remember which pc the outstanding read belongs to
  always_ff @(posedge clk_i) begin
    if (rom_req_o.valid) begin
      inflight_pc_q <= pc_q;
    end
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  // once dead nothing leaves fetch, neither a read nor a late response
  a_no_fetch_after_exc : assert property (
    @(posedge clk_i) disable iff (!rstn_i)
    (state_q == FS_EXC) |-> (!rom_req_o.valid && !push_o)
  ) else $error("fetch active in FS_EXC");

endmodule

`default_nettype wire

//--- fetch/instr_rom.sv
// instruction ROM with one cycle read latency
// contents come from program.hex at start of simulation
// words beyond ROM_WORDS read back as a NOP

`default_nettype none

module instr_rom (
  input  logic                clk_i,
  input  logic                rstn_i,
  input  fetch_pkg::rom_req_t req_i,
  output fetch_pkg::rom_rsp_t rsp_o
);
  import fetch_pkg::*;
  import isa_pkg::*;

  logic [31:0] mem [ROM_WORDS];
  logic        in_range;

  initial begin
    $readmemh("program.hex", mem);
  end

  assign in_range = (req_i.addr < 30'(ROM_WORDS));

  // response valid mirrors the request one cycle later
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      rsp_o.valid <= 1'b0;
    end else begin
      rsp_o.valid <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      rsp_o.data <= in_range ? mem[req_i.addr[ROM_AW-1:0]] : NOP_INSTR;
    end
  end

endmodule

`default_nettype wire

//--- program.hex
// one 32-bit instruction word per line, from byte address 0x00 upward
// trailing comment: byte address and assembly
00100093 // 00 addi x1, x0, 1
00200113 // 04 addi x2, x0, 2
002081b3 // 08 add  x3, x1, x2
12345237 // 0c lui  x4, 0x12345
0200006f // 10 jal  x0, +0x20 -> 30
fff00f93 // 14 skipped
fff00f93 // 18 skipped
fff00f93 // 1c skipped
fff00f93 // 20 skipped
fff00f93 // 24 skipped
fff00f93 // 28 skipped
fff00f93 // 2c skipped
00302023 // 30 sw   x3, 0(x0)
00002283 // 34 lw   x5, 0(x0)
00000317 // 38 auipc x6, 0
00000463 // 3c beq  x0, x0, +8 (not taken here)
00008067 // 40 jalr x0, 0(x1) (not taken here)
0ff0000f // 44 fence
00c003ef // 48 jal  x7, +0x0c -> 54
fff00f93 // 4c skipped
fff00f93 // 50 skipped
00000073 // 54 ecall
0000000b // 58 custom-0, illegal class
0100006f // 5c jal  x0, +0x10 -> 6c
0060006f // 60 jal  x0, +6 -> 66, misaligned
fff00f93 // 64 never delivered
fff00f93 // 68 never delivered
0020e433 // 6c or   x8, x1, x2
ff1ff06f // 70 jal  x0, -0x10 -> 60

//--- run.sh
#!/bin/sh
# compile with Verilator and run from the project root, program.hex is read from here
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_fetch_top -f build.f -o tb_fetch_top \
  && ./obj_dir/tb_fetch_top | tee sim.log \
  && ! grep -q "Simulation failed" sim.log \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

//--- test/tb_clock.sv
// free running clock for the testbench
// starts low, first rising edge after half a period

`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk_o = 1'b0;

  always #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50% duty

endmodule

`default_nettype wire

//--- test/tb_fetch_top.sv
// testbench for the fetch front end, run from the project root
// reference model walks program.hex by the RV32I JAL rules
// stall pattern on dec_ready comes from a fixed xorshift seed
// run ends once the misaligned JAL has raised its exception

`default_nettype none

module tb_fetch_top;
  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import fetch_pkg::*;

  localparam logic [31:0] BOOT_ADDR      = 32'h0000_0000;
  localparam logic [31:0] SEED           = 32'h79b2;
  localparam int          RESET_CYCLES   = 16;
  localparam int          QUIET_CYCLES   = 50;
  localparam int          EXP_INSTRS     = 18;  // instructions delivered by program.hex
  // 40 cycles per instruction covers stalls and redirect bubbles
  localparam int          TIMEOUT_CYCLES = EXP_INSTRS * 10 * FETCH_BUF_DEPTH + RESET_CYCLES;

  logic        clk;
  logic        rstn      = 1'b0;
  logic        dec_ready = 1'b1;
  decoded_t    dec;
  logic        dec_valid;
  logic        exception;
  logic [31:0] fault_addr;

  logic [31:0] prog [ROM_WORDS];     // private copy of the program
  logic [31:0] rnd_state = SEED;
  int unsigned cycle_cnt = 0;
  int unsigned run_cycles;           // cycles since reset release
  logic [31:0] exp_pc;               // pc of the next instruction due at dec_o
  logic        done_q;               // misaligned JAL already delivered
  logic [31:0] exp_instr;
  logic [31:0] exp_offset;           // J-type offset of the due instruction
  logic [31:0] exp_target;
  opcode_e     exp_op;
  logic        exp_misaligned;
  logic        handshake;
  logic        stalled_q;
  decoded_t    dec_prev_q;

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // major opcode lives in bits 6:2, bits 1:0 must be 11
  function automatic opcode_e class_of(input logic [31:0] instr);
    if (instr[1:0] != 2'b11) return OP_ILLEGAL;
    case (instr[6:2])
      5'b01101: return OP_LUI;
      5'b00101: return OP_AUIPC;
      5'b11011: return OP_JAL;
      5'b11001: return OP_JALR;
      5'b11000: return OP_BRANCH;
      5'b00000: return OP_LOAD;
      5'b01000: return OP_STORE;
      5'b00100: return OP_IMM;
      5'b01100: return OP_REG;
      5'b00011: return OP_FENCE;
      5'b11100: return OP_SYSTEM;
      default:  return OP_ILLEGAL;
    endcase
  endfunction

  // sign extended J-type byte offset
  function automatic logic [31:0] jal_offset(input logic [31:0] instr);
    return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  endfunction

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////
  // clock, DUT, stimulus
  //////////////////////////////

  tb_clock #(.PERIOD_NS(20)) u_tb_clock (.clk_o(clk));

  fetch_top #(.BOOT_ADDR(BOOT_ADDR)) u_fetch_top (
    .clk_i        (clk),
    .rstn_i       (rstn),
    .dec_ready_i  (dec_ready),
    .dec_o        (dec),
    .dec_valid_o  (dec_valid),
    .exception_o  (exception),
    .fault_addr_o (fault_addr)
  );

  // ready low on roughly 3 cycles in 10
  always @(negedge clk) begin
    rnd_state <= next_random(rnd_state);
    dec_ready <= (rnd_state % 32'd10) >= 32'd3;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  assign handshake      = dec_valid && dec_ready;
  assign exp_instr      = prog[exp_pc[ROM_AW+1:2]];
  assign exp_op         = class_of(exp_instr);
  assign exp_offset     = jal_offset(exp_instr);
  assign exp_target     = exp_pc + exp_offset;
  assign exp_misaligned = (exp_op == OP_JAL) && (exp_target[1:0] != 2'b00);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      exp_pc     <= BOOT_ADDR;
      done_q     <= 1'b0;
      run_cycles <= 0;
    end else begin
      run_cycles <= run_cycles + 1;
      if (handshake && !done_q) begin
        if (exp_misaligned) begin
          done_q <= 1'b1;              // exp_pc stays on the faulting JAL
        end else if (exp_op == OP_JAL) begin
          exp_pc <= exp_target;        // next instruction skipped by the flush
        end else begin
          exp_pc <= exp_pc + 32'd4;
        end
      end
    end
  end

  // copy of dec_o for the back-pressure check
  always_ff @(posedge clk) begin
    if (!rstn) begin
      stalled_q <= 1'b0;
    end else begin
      stalled_q <= dec_valid && !dec_ready;
    end
    dec_prev_q <= dec;
  end

  //////////////////////////////
  // checks
  //////////////////////////////

  a_pc : assert property (@(posedge clk) disable iff (!rstn)
    handshake |-> (dec.pc == exp_pc))
  else begin
    $display("CHECK FAILED: dec_o.pc = %h, expected %h", $sampled(dec.pc), $sampled(exp_pc));
    abort_run();
  end

  a_instr : assert property (@(posedge clk) disable iff (!rstn)
    handshake |-> (dec.instr == exp_instr))
  else begin
    $display("CHECK FAILED: dec_o.instr = %h, expected %h",
             $sampled(dec.instr), $sampled(exp_instr));
    abort_run();
  end

  a_op : assert property (@(posedge clk) disable iff (!rstn)
    handshake |-> (dec.op == exp_op))
  else begin
    $display("CHECK FAILED: dec_o.op = %h, expected %h", $sampled(dec.op), $sampled(exp_op));
    abort_run();
  end

  a_rd : assert property (@(posedge clk) disable iff (!rstn)
    handshake |-> (dec.rd == exp_instr[11:7]))
  else begin
    $display("CHECK FAILED: dec_o.rd = %h, expected %h",
             $sampled(dec.rd), $sampled(exp_instr[11:7]));
    abort_run();
  end

  // offset field as laid out by the J-type format
  a_jal_imm : assert property (@(posedge clk) disable iff (!rstn)
    handshake |-> (dec.jal_imm == exp_offset[20:0]))
  else begin
    $display("CHECK FAILED: dec_o.jal_imm = %h, expected %h",
             $sampled(dec.jal_imm), $sampled(exp_offset[20:0]));
    abort_run();
  end

  // held slot keeps valid and data under a stall
  a_hold : assert property (@(posedge clk) disable iff (!rstn)
    stalled_q |-> (dec_valid && dec == dec_prev_q))
  else begin
    $display("CHECK FAILED: dec_o = %h, expected %h held with dec_valid_o = %h",
             $sampled(dec), $sampled(dec_prev_q), $sampled(dec_valid));
    abort_run();
  end

  a_nothing_after_fault : assert property (@(posedge clk) disable iff (!rstn)
    done_q |-> !dec_valid)
  else begin
    $display("CHECK FAILED: dec_valid_o = %h after the faulting JAL, expected 0",
             $sampled(dec_valid));
    abort_run();
  end

  // only the misaligned JAL may raise the exception
  a_exc_time : assert property (@(posedge clk) disable iff (!rstn)
    exception |-> (done_q || exp_misaligned))
  else begin
    $display("CHECK FAILED: exception_o = %h at pc %h, expected 0",
             $sampled(exception), $sampled(exp_pc));
    abort_run();
  end

  a_fault_addr : assert property (@(posedge clk) disable iff (!rstn)
    exception |-> (fault_addr == exp_target))
  else begin
    $display("CHECK FAILED: fault_addr_o = %h, expected %h",
             $sampled(fault_addr), $sampled(exp_target));
    abort_run();
  end

  a_reset_out : assert property (@(posedge clk)
    !rstn |=> (dec.instr == NOP_INSTR && !dec_valid && !exception))
  else begin
    $display("CHECK FAILED: dec_o.instr = %h dec_valid_o = %h exception_o = %h, expected %h 0 0",
             $sampled(dec.instr), $sampled(dec_valid), $sampled(exception), NOP_INSTR);
    abort_run();
  end

  a_first_latency : assert property (@(posedge clk) disable iff (!rstn)
    dec_valid |-> (run_cycles >= 3))
  else begin
    $display("dec_valid_o rose only %0d cycles after reset release", $sampled(run_cycles));
    abort_run();
  end

  //////////////////////////////
  // run control
  //////////////////////////////

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the misaligned JAL never raised its exception",
               cycle_cnt);
      abort_run();
    end
  end

  initial begin
    $readmemh("program.hex", prog);
    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;
    while (!(done_q && exception)) @(negedge clk);
    repeat (QUIET_CYCLES) @(negedge clk);   // nothing may move after the fault
    if (exception && fault_addr == exp_target && !dec_valid) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("CHECK FAILED: exception_o = %h fault_addr_o = %h, expected 1 and %h",
               exception, fault_addr, exp_target);
      abort_run();
    end
  end

endmodule

`default_nettype wire
